// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = eq_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/spi_reg_pkg.sv
design/fir_pkg.sv
design/spi_slave.sv
design/reg_ctrl.sv
design/coef_bank.sv
design/fir_eq.sv
design/eq_top.sv
verif/eq_tb.sv

// File: design/coef_bank.sv
`timescale 1ns/1ps

module coef_bank
    import fir_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      we,
    input  coef_sel_t sel,
    input  coef_t     wdata,
    output coef_t     rdata,
    input  logic      act_eq,
    output coef_set_t act_set
);

    coef_set_t               bank_q [NUM_EQ];
    logic [EQ_IDX_BITS-1:0]  eq_idx;
    logic [TAP_IDX_BITS-1:0] tap_idx;
    logic                    sel_ok;

    //////////////////////////////////////////////////
    // Host access port
    //////////////////////////////////////////////////

    // Index bits only, range checked separately
    assign eq_idx  = sel.eq[EQ_IDX_BITS-1:0];
    assign tap_idx = sel.tap[TAP_IDX_BITS-1:0];
    assign sel_ok  = (sel.eq < NUM_EQ) && (sel.tap < NUM_TAPS);

    // All sets start at zero, filter output silent until loaded
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int e = 0; e < NUM_EQ; e++) begin
                bank_q[e] <= '0;
            end
        end else if (we && sel_ok) begin
            // Guard against aliasing on truncated index
            bank_q[eq_idx][tap_idx] <= wdata;
        end
    end

    // Combinational readback
    assign rdata = sel_ok ? bank_q[eq_idx][tap_idx] : '0;

    //////////////////////////////////////////////////
    // Filter side
    //////////////////////////////////////////////////

    // Whole active set, all taps in parallel
    assign act_set = bank_q[act_eq];

endmodule

// File: design/eq_top.sv
`timescale 1ns/1ps

module eq_top
    import spi_reg_pkg::*;
    import fir_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 spi_cs_n,
    input  logic                 spi_clk,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    input  logic [DATA_BITS-1:0] mpio_in,
    output logic [DATA_BITS-1:0] mpio_out,
    input  sample_t              sample_in,
    input  logic                 sample_valid,
    output sample_t              sample_out,
    output logic                 out_valid
);

    // SPI to controller
    spi_req_t             req;
    logic                 rd_stb;
    logic                 wr_stb;
    logic [DATA_BITS-1:0] rdata;
    // Controller to bank
    logic                 coef_we;
    coef_sel_t            coef_sel;
    coef_t                coef_wdata;
    coef_t                coef_rdata;
    // Filter configuration
    logic                 fir_en;
    logic                 act_eq;
    coef_set_t            act_set;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////

    spi_slave spi_slave0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .spi_cs_n (spi_cs_n),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .req      (req),
        .rd_stb   (rd_stb),
        .wr_stb   (wr_stb),
        .rdata    (rdata)
    );

    reg_ctrl reg_ctrl0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .rd_stb     (rd_stb),
        .wr_stb     (wr_stb),
        .rdata      (rdata),
        .mpio_in    (mpio_in),
        .mpio_out   (mpio_out),
        .coef_we    (coef_we),
        .coef_sel   (coef_sel),
        .coef_wdata (coef_wdata),
        .coef_rdata (coef_rdata),
        .fir_en     (fir_en),
        .act_eq     (act_eq)
    );

    //////////////////////////////////////////////////
    // Audio side
    //////////////////////////////////////////////////

    coef_bank coef_bank0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (coef_we),
        .sel     (coef_sel),
        .wdata   (coef_wdata),
        .rdata   (coef_rdata),
        .act_eq  (act_eq),
        .act_set (act_set)
    );

    fir_eq fir_eq0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (fir_en),
        .coefs        (act_set),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_out   (sample_out),
        .out_valid    (out_valid)
    );

endmodule

// File: design/fir_eq.sv
`timescale 1ns/1ps

module fir_eq
    import fir_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      en,
    input  coef_set_t coefs,
    input  sample_t   sample_in,
    input  logic      sample_valid,
    output sample_t   sample_out,
    output logic      out_valid
);

    sample_t dly_q  [NUM_TAPS-1];
    sample_t tap_in [NUM_TAPS];
    prod_t   prod_q [NUM_TAPS];
    sample_t byp_q;
    logic    vld_q;
    acc_t    acc;
    acc_t    acc_shr;
    sample_t sat;

    // Tap 0 is the new sample and the rest come from the delay line
    always_comb begin
        tap_in[0] = sample_in;
        for (int i = 1; i < NUM_TAPS; i++) begin
            tap_in[i] = dly_q[i-1];
        end
    end

    //////////////////////////////////////////////////
    // Stage 1 delay line and products
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_TAPS - 1; i++) begin
                dly_q[i] <= '0;
            end
            vld_q     <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (sample_valid) begin
                for (int i = 0; i < NUM_TAPS - 1; i++) begin
                    dly_q[i] <= tap_in[i];
                end
            end
            vld_q     <= sample_valid;
            out_valid <= vld_q;
        end
    end

    // Products and bypass copy move only with a new sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                prod_q[i] <= '0;
            end
            byp_q      <= '0;
            sample_out <= '0;
        end else begin
            if (sample_valid) begin
                for (int i = 0; i < NUM_TAPS; i++) begin
                    prod_q[i] <= tap_in[i] * $signed(coefs[i]);
                end
                byp_q <= sample_in;
            end
            if (vld_q) begin
                sample_out <= en ? sat : byp_q;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 2 sums, scales and saturates
    //////////////////////////////////////////////////

    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc = acc + prod_q[i];
        end
        // Arithmetic shift back to Q1.15 keeps the sign
        acc_shr = acc >>> Q_FRAC;
        if (acc_shr > SAMPLE_MAX) begin
            sat = SAMPLE_MAX;
        end else if (acc_shr < SAMPLE_MIN) begin
            sat = SAMPLE_MIN;
        end else begin
            sat = acc_shr[SAMPLE_BITS-1:0];
        end
    end

    // Fixed two-cycle latency even for back-to-back samples
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(sample_valid, 2));

endmodule

// File: design/fir_pkg.sv
package fir_pkg;

    //////////////////////////////////////////////////
    // Filter dimensions
    //////////////////////////////////////////////////

    localparam int NUM_TAPS     = 4;
    localparam int NUM_EQ       = 2;
    localparam int SAMPLE_BITS  = 16;
    localparam int COEF_BITS    = 16;
    localparam int EQ_SEL_BITS  = 6;
    localparam int TAP_SEL_BITS = 10;
    localparam int EQ_IDX_BITS  = $clog2(NUM_EQ);
    localparam int TAP_IDX_BITS = $clog2(NUM_TAPS);

    // Q1.15 coefficients
    localparam int Q_FRAC    = 15;
    localparam int PROD_BITS = SAMPLE_BITS + COEF_BITS;
    // Headroom for the tap sum
    localparam int ACC_BITS  = PROD_BITS + $clog2(NUM_TAPS);

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;
    typedef logic signed [COEF_BITS-1:0]   coef_t;
    typedef logic signed [PROD_BITS-1:0]   prod_t;
    typedef logic signed [ACC_BITS-1:0]    acc_t;

    // Saturation limits
    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

    // One equalizer, tap 0 in the low word
    typedef coef_t [NUM_TAPS-1:0] coef_set_t;

    // Layout of the EQ/tap select register
    typedef struct packed {
        logic [EQ_SEL_BITS-1:0]  eq;
        logic [TAP_SEL_BITS-1:0] tap;
    } coef_sel_t;

endpackage

// File: design/reg_ctrl.sv
`timescale 1ns/1ps

module reg_ctrl
    import spi_reg_pkg::*;
    import fir_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  spi_req_t             req,
    input  logic                 rd_stb,
    input  logic                 wr_stb,
    output logic [DATA_BITS-1:0] rdata,
    input  logic [DATA_BITS-1:0] mpio_in,
    output logic [DATA_BITS-1:0] mpio_out,
    output logic                 coef_we,
    output coef_sel_t            coef_sel,
    output coef_t                coef_wdata,
    input  coef_t                coef_rdata,
    output logic                 fir_en,
    output logic                 act_eq
);

    logic [DATA_BITS-1:0] ctrl_q;
    coef_sel_t            sel_q;
    logic                 sel_ok;
    logic [DATA_BITS-1:0] rd_mux;

    // Select must point inside the bank
    assign sel_ok = (sel_q.eq < NUM_EQ) && (sel_q.tap < NUM_TAPS);

    //////////////////////////////////////////////////
    // Register writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            sel_q    <= '0;
            mpio_out <= '0;
        end else if (wr_stb) begin
            case (req.addr)
                REG_CONTROL:    ctrl_q   <= req.wdata;
                REG_EQ_TAP_SEL: sel_q    <= coef_sel_t'(req.wdata);
                REG_MPIO:       mpio_out <= req.wdata;
                // Coef data goes to the bank, unmapped writes drop
                default: ;
            endcase
        end
    end

    // Coefficient write port, fires in the wr_stb cycle
    assign coef_we    = wr_stb && (req.addr == REG_COEF_DATA) && sel_ok;
    assign coef_sel   = sel_q;
    assign coef_wdata = coef_t'(req.wdata);

    // Filter configuration
    assign fir_en = ctrl_q[CTRL_FIR_EN];
    assign act_eq = ctrl_q[CTRL_ACT_EQ];

    //////////////////////////////////////////////////
    // Register reads
    //////////////////////////////////////////////////

    always_comb begin
        rd_mux = DEAD_WORD;
        case (req.addr)
            REG_CONTROL:    rd_mux = ctrl_q;
            REG_EQ_TAP_SEL: rd_mux = sel_q;
            // MPIO reads the input pins, not the written value
            REG_MPIO:       rd_mux = mpio_in;
            REG_COEF_DATA: begin
                if (sel_ok) begin
                    rd_mux = coef_rdata;
                end
            end
            default: ;
        endcase
    end

    // Read word ready the cycle after rd_stb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd_stb) begin
            rdata <= rd_mux;
        end
    end

    // Bank never sees a write outside its sets
    assert property (@(posedge clk) disable iff (!arst_n)
        coef_we |-> (coef_sel.eq < NUM_EQ) && (coef_sel.tap < NUM_TAPS));

endmodule

// File: design/spi_reg_pkg.sv
package spi_reg_pkg;

    //////////////////////////////////////////////////
    // SPI frame layout
    //////////////////////////////////////////////////

    // Op bit, then address, then data, MSB first
    localparam int FRAME_BITS = 32;
    localparam int ADDR_BITS  = 15;
    localparam int DATA_BITS  = 16;
    localparam int HDR_BITS   = FRAME_BITS - DATA_BITS;
    localparam int CNT_BITS   = $clog2(FRAME_BITS);

    // Read value for unmapped or out-of-range locations
    localparam logic [DATA_BITS-1:0] DEAD_WORD = 16'hdead;

    // Control register bit positions
    localparam int CTRL_FIR_EN = 0;
    localparam int CTRL_ACT_EQ = 1;

    // Frame bit 31, high for read
    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } spi_op_e;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    typedef enum logic [ADDR_BITS-1:0] {
        REG_CONTROL    = 15'd0,
        REG_EQ_TAP_SEL = 15'd1,
        REG_MPIO       = 15'd2,
        REG_COEF_DATA  = 15'd3
    } reg_addr_e;

    // Decoded frame handed to the register controller
    typedef struct packed {
        spi_op_e                op;
        logic [ADDR_BITS-1:0]   addr;
        logic [DATA_BITS-1:0]   wdata;
    } spi_req_t;

    // Deframer states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_DATA
    } spi_state_e;

endpackage

// File: design/spi_slave.sv
`timescale 1ns/1ps

module spi_slave
    import spi_reg_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 spi_cs_n,
    input  logic                 spi_clk,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    output spi_req_t             req,
    output logic                 rd_stb,
    output logic                 wr_stb,
    input  logic [DATA_BITS-1:0] rdata
);

    logic [1:0]           sclk_sync;
    logic [1:0]           cs_sync;
    logic [1:0]           mosi_sync;
    logic                 sclk_prev;
    logic                 cs_prev;
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic                 cs_fall;
    logic                 cs_idle;
    logic                 mosi_bit;
    spi_state_e           state;
    logic [CNT_BITS-1:0]  bit_cnt;
    logic [DATA_BITS-1:0] shreg;
    logic [DATA_BITS-1:0] txreg;
    logic                 rd_pend;

    //////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    //////////////////////////////////////////////////

    // cs_n resets high so no false frame start
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clk};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_prev <= sclk_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign cs_fall   = ~cs_sync[1] & cs_prev;
    assign cs_idle   = cs_sync[1];
    // MOSI delayed as much as SCLK, so sampled on the same edge
    assign mosi_bit  = mosi_sync[1];

    //////////////////////////////////////////////////
    // Deframer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            shreg    <= '0;
            txreg    <= '0;
            req      <= '0;
            rd_stb   <= 1'b0;
            wr_stb   <= 1'b0;
            rd_pend  <= 1'b0;
            spi_miso <= 1'b0;
        end else begin
            rd_stb  <= 1'b0;
            wr_stb  <= 1'b0;
            rd_pend <= rd_stb;
            case (state)
                ST_IDLE: begin
                    spi_miso <= 1'b0;
                    bit_cnt  <= '0;
                    // Fresh frame starts on the cs_n falling edge only
                    if (cs_fall) begin
                        txreg <= '0;
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    // Early cs_n rise drops the frame
                    if (cs_idle) begin
                        state <= ST_IDLE;
                    end else if (sclk_rise) begin
                        shreg   <= {shreg[DATA_BITS-2:0], mosi_bit};
                        bit_cnt <= bit_cnt + 1'b1;
                        // 16th bit, op sits at shreg[14]
                        if (bit_cnt == CNT_BITS'(HDR_BITS - 1)) begin
                            req.op   <= spi_op_e'(shreg[HDR_BITS-2]);
                            req.addr <= {shreg[ADDR_BITS-2:0], mosi_bit};
                            rd_stb   <= (shreg[HDR_BITS-2] == OP_READ);
                            state    <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (cs_idle) begin
                        state <= ST_IDLE;
                    end else begin
                        // Mode 0, MISO moves on the falling edge
                        if (sclk_fall) begin
                            spi_miso <= txreg[DATA_BITS-1];
                            txreg    <= {txreg[DATA_BITS-2:0], 1'b0};
                        end
                        if (sclk_rise) begin
                            shreg   <= {shreg[DATA_BITS-2:0], mosi_bit};
                            bit_cnt <= bit_cnt + 1'b1;
                            // Last bit, write strobe only for write frames
                            if (bit_cnt == CNT_BITS'(FRAME_BITS - 1)) begin
                                req.wdata <= {shreg[DATA_BITS-2:0], mosi_bit};
                                wr_stb    <= (req.op == OP_WRITE);
                                state     <= ST_IDLE;
                            end
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // Read word lands one cycle after rd_stb, well before the next fall
            if (rd_pend) begin
                txreg <= rdata;
            end
        end
    end

    // One frame never yields both strobes
    assert property (@(posedge clk) disable iff (!arst_n) !(rd_stb && wr_stb));

endmodule

// File: verif/eq_cases.txt
# kind addr_or_sample data_or_gap expected, all hex
# W write, X write cut after 20 bits, R read, M read of random mpio_in, S sample
R 0000 0000 0000
W 0000 a5a4 0000
R 0000 0000 a5a4
W 0001 1c03 0000
R 0001 0000 1c03
W 0010 ffff 0000
W 7fff 1234 0000
R 0010 0000 dead
R 7fff 0000 dead
R 0000 0000 a5a4
R 0001 0000 1c03
W 0002 3c5a 3c5a
M 0002 0000 0000
M 0002 0000 0000
X 0000 0fff 3c5a
R 0000 0000 a5a4
X 0002 ffff 3c5a
W 0001 0000 3c5a
W 0003 7fff 3c5a
W 0001 0003 3c5a
W 0003 8001 3c5a
W 0001 0400 3c5a
W 0003 4000 3c5a
W 0001 0401 3c5a
W 0003 2000 3c5a
W 0001 0402 3c5a
W 0003 e000 3c5a
W 0001 0403 3c5a
W 0003 1000 3c5a
W 0001 0000 3c5a
R 0003 0000 7fff
W 0001 0003 3c5a
R 0003 0000 8001
W 0001 0402 3c5a
R 0003 0000 e000
W 0001 0800 3c5a
W 0003 1111 3c5a
R 0001 0000 0800
R 0003 0000 dead
W 0001 0004 3c5a
W 0003 2222 3c5a
R 0003 0000 dead
W 0001 0000 3c5a
R 0003 0000 7fff
W 0001 0400 3c5a
R 0003 0000 4000
W 0000 0003 3c5a
R 0000 0000 0003
S 1000 0003 0800
S 2000 0003 1400
S 7fff 0003 43ff
S 7fff 0000 59ff
S 8000 0000 c400
S 7fff 0000 0fff
S 7fff 0000 7fff
S 8000 0000 b000
S 8000 0000 9000
S 8000 0000 cfff
S 7fff 0000 2fff
S 8000 0000 efff
S 8000 0000 8000
W 0000 0002 3c5a
R 0000 0000 0002
S 1234 0002 1234
S fedc 0000 fedc

// File: verif/eq_tb.sv
`timescale 1ns/1ps

module eq_tb
    import spi_reg_pkg::*;
    import fir_pkg::*;
();

    // SPI half period in clk cycles
    localparam int HALF_CLKS   = 4;
    localparam int RST_CYCLES  = 4;
    localparam int OUT_TIMEOUT = 20;
    localparam int LATENCY     = 2;

    logic                 clk;
    logic                 arst_n;
    logic                 spi_cs_n;
    logic                 spi_clk;
    logic                 spi_mosi;
    logic                 spi_miso;
    logic [DATA_BITS-1:0] mpio_in;
    logic [DATA_BITS-1:0] mpio_out;
    sample_t              sample_in;
    logic                 sample_valid;
    sample_t              sample_out;
    logic                 out_valid;

    integer               seed;
    int                   cyc_cnt = 0;
    // Pending sample burst with one entry per S line
    sample_t              smp_q [$];
    int                   gap_q [$];
    logic [DATA_BITS-1:0] exp_q [$];
    int                   line_q [$];
    int                   sent_q [$];

    eq_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .spi_cs_n     (spi_cs_n),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_miso     (spi_miso),
        .mpio_in      (mpio_in),
        .mpio_out     (mpio_out),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_out   (sample_out),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Cycle stamp for latency checks
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    //////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [DATA_BITS-1:0] expected,
                               input logic [DATA_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            stop_run("value mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // SPI host, mode 0
    //////////////////////////////////////////////////

    // Short nbits cuts the frame with an early cs_n rise
    task automatic spi_frame(input spi_req_t frame, input int nbits,
                             output logic [DATA_BITS-1:0] miso_word);
        logic [FRAME_BITS-1:0] bits;
        bits      = frame;
        miso_word = '0;
        @(negedge clk);
        spi_cs_n = 1'b0;
        repeat (HALF_CLKS) @(negedge clk);
        for (int i = 0; i < nbits; i++) begin
            // MOSI moves while spi_clk is low
            spi_mosi = bits[FRAME_BITS-1-i];
            repeat (HALF_CLKS) @(negedge clk);
            // Host samples MISO just before its rising edge
            if (i >= HDR_BITS) begin
                miso_word = {miso_word[DATA_BITS-2:0], spi_miso};
            end
            spi_clk = 1'b1;
            repeat (HALF_CLKS) @(negedge clk);
            spi_clk = 1'b0;
        end
        repeat (HALF_CLKS) @(negedge clk);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        // Room for wr_stb and the register update
        repeat (2 * HALF_CLKS) @(negedge clk);
    endtask

    task automatic reg_write(input logic [ADDR_BITS-1:0] addr,
                             input logic [DATA_BITS-1:0] data, input int nbits);
        spi_req_t             frame;
        logic [DATA_BITS-1:0] unused_word;
        frame.op    = OP_WRITE;
        frame.addr  = addr;
        frame.wdata = data;
        spi_frame(frame, nbits, unused_word);
    endtask

    task automatic reg_read(input logic [ADDR_BITS-1:0] addr,
                            output logic [DATA_BITS-1:0] data);
        spi_req_t frame;
        frame.op    = OP_READ;
        frame.addr  = addr;
        frame.wdata = '0;
        spi_frame(frame, FRAME_BITS, data);
    endtask

    //////////////////////////////////////////////////
    // Sample stream
    //////////////////////////////////////////////////

    task automatic wait_output();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > OUT_TIMEOUT) begin
                stop_run("timed out waiting for out_valid");
            end
        end while (!out_valid);
    endtask

    // Driver and collector run side by side so samples can overlap
    task automatic run_burst();
        fork
            begin
                for (int i = 0; i < smp_q.size(); i++) begin
                    repeat (gap_q[i]) begin
                        @(negedge clk);
                        sample_valid = 1'b0;
                    end
                    @(negedge clk);
                    sample_in    = smp_q[i];
                    sample_valid = 1'b1;
                    sent_q.push_back(cyc_cnt);
                end
                @(negedge clk);
                sample_valid = 1'b0;
            end
            begin
                for (int i = 0; i < exp_q.size(); i++) begin
                    wait_output();
                    check_value($sformatf("line %0d sample_out", line_q[i]),
                                exp_q[i], sample_out);
                    check_value($sformatf("line %0d latency", line_q[i]),
                                16'(LATENCY), 16'(cyc_cnt - sent_q[i]));
                end
            end
        join
        smp_q.delete();
        gap_q.delete();
        exp_q.delete();
        line_q.delete();
        sent_q.delete();
    endtask

    //////////////////////////////////////////////////
    // Case file runner
    //////////////////////////////////////////////////

    initial begin
        string                line;
        string                name;
        int                   fd;
        int                   fields;
        int                   line_no;
        int                   case_cnt;
        logic [7:0]           kind;
        logic [DATA_BITS-1:0] col_a;
        logic [DATA_BITS-1:0] col_b;
        logic [DATA_BITS-1:0] col_exp;
        logic [DATA_BITS-1:0] rd_word;
        logic [31:0]          rnd;

        spi_cs_n     = 1'b1;
        spi_clk      = 1'b0;
        spi_mosi     = 1'b0;
        mpio_in      = '0;
        sample_in    = '0;
        sample_valid = 1'b0;
        seed         = 32'h41f9;
        line_no      = 0;
        case_cnt     = 0;

        arst_n = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_value("reset mpio_out", '0, mpio_out);
        check_value("reset spi_miso", '0, 16'(spi_miso));
        check_value("reset out_valid", '0, 16'(out_valid));

        fd = $fopen("verif/eq_cases.txt", "r");
        if (fd == 0) begin
            stop_run("could not open verif/eq_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            // Skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%c %h %h %h", kind, col_a, col_b, col_exp);
            if (fields != 4) begin
                stop_run($sformatf("malformed case on line %0d", line_no));
            end
            // Any other kind closes an open burst
            if (kind != "S" && smp_q.size() > 0) begin
                run_burst();
            end
            name = $sformatf("line %0d %c %h", line_no, kind, col_a);
            case (kind)
                "W": begin
                    reg_write(col_a[ADDR_BITS-1:0], col_b, FRAME_BITS);
                    check_value({name, " mpio_out"}, col_exp, mpio_out);
                end
                "X": begin
                    // cs_n rises after 20 bits
                    reg_write(col_a[ADDR_BITS-1:0], col_b, 20);
                    check_value({name, " mpio_out"}, col_exp, mpio_out);
                end
                "R": begin
                    reg_read(col_a[ADDR_BITS-1:0], rd_word);
                    check_value(name, col_exp, rd_word);
                end
                "M": begin
                    @(negedge clk);
                    rnd     = $random(seed);
                    mpio_in = rnd[DATA_BITS-1:0];
                    reg_read(col_a[ADDR_BITS-1:0], rd_word);
                    check_value(name, mpio_in, rd_word);
                end
                "S": begin
                    smp_q.push_back(sample_t'(col_a));
                    gap_q.push_back(int'(col_b));
                    exp_q.push_back(col_exp);
                    line_q.push_back(line_no);
                end
                default: begin
                    stop_run($sformatf("unknown case kind on line %0d", line_no));
                end
            endcase
            case_cnt++;
        end
        if (smp_q.size() > 0) begin
            run_burst();
        end
        $fclose(fd);

        if (case_cnt == 0) begin
            stop_run("case file held no cases");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule
